// ==== gpu_core_defs.svh ====
// GPU core width macros
`ifndef GPU_CORE_DEFS_SVH
`define GPU_CORE_DEFS_SVH

// Datapath
`define GPU_WORD_W    8       // Data and register width
`define GPU_ADDR_W    8       // Program and data address width

// Instruction word
`define GPU_INSTR_W   16
`define GPU_OPCODE_W  4

// Register file
`define GPU_NUM_REGS  16
`define GPU_REG_SEL_W 4       // Register address bits

// Condition flags and branch mask
`define GPU_NZP_W     3

`endif

// ==== gpu_core_pkg.sv ====
// GPU core shared types
`default_nettype none

`include "gpu_core_defs.svh"

package gpu_core_pkg;

    typedef enum logic [`GPU_OPCODE_W-1:0] {
        OP_NOP   = 4'd0,
        OP_BRNZP = 4'd1,
        OP_CMP   = 4'd2,
        OP_ADD   = 4'd3,
        OP_SUB   = 4'd4,
        OP_MUL   = 4'd5,
        OP_DIV   = 4'd6,
        OP_LDR   = 4'd7,
        OP_STR   = 4'd8,
        OP_CONST = 4'd9,
        OP_RET   = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_REQUEST, ST_WAIT, ST_EXECUTE, ST_UPDATE, ST_DONE
    } core_state_t;

    // Register write source
    typedef enum logic [1:0] {
        SRC_ALU = 2'd0,
        SRC_MEM = 2'd1,
        SRC_IMM = 2'd2
    } reg_src_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_MUL = 2'd2,
        ALU_DIV = 2'd3
    } alu_op_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [`GPU_REG_SEL_W-1:0] rd;
        logic [`GPU_REG_SEL_W-1:0] rs;
        logic [`GPU_REG_SEL_W-1:0] rt;
    } instr_reg_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [`GPU_REG_SEL_W-1:0] rd;
        logic [`GPU_WORD_W-1:0]    imm;
    } instr_imm_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [`GPU_NZP_W-1:0]  nzp;     // Branch condition mask
        logic                   spare;
        logic [`GPU_ADDR_W-1:0] target;
    } instr_br_t;

    // Same 16 bits, three field layouts
    typedef union packed {
        instr_reg_t reg_fmt;
        instr_imm_t imm_fmt;
        instr_br_t  br_fmt;
    } instr_t;

    typedef struct packed {
        logic [`GPU_REG_SEL_W-1:0] rd;
        logic [`GPU_REG_SEL_W-1:0] rs;
        logic [`GPU_REG_SEL_W-1:0] rt;
        logic [`GPU_NZP_W-1:0]     nzp;
        logic [`GPU_WORD_W-1:0]    imm;     // CONST value or branch target
        logic                      reg_write_en;
        logic                      mem_read_en;
        logic                      mem_write_en;
        logic                      nzp_write_en;
        reg_src_t                  reg_input_sel;
        alu_op_t                   alu_arith_sel;
        logic                      alu_cmp_sel;
        logic                      pc_branch;
        logic                      ret;
    } decoded_ctrl_t;

    typedef struct packed {
        logic                   write;
        logic [`GPU_ADDR_W-1:0] addr;
        logic [`GPU_WORD_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== decoder.sv ====
// Instruction decoder
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module decoder (
    input  logic                        clk,
    input  logic                        reset,
    input  gpu_core_pkg::core_state_t   core_state,
    input  gpu_core_pkg::instr_t        instruction,
    output gpu_core_pkg::decoded_ctrl_t ctrl
);
    import gpu_core_pkg::*;

    decoded_ctrl_t next_ctrl;

    always_comb begin
        next_ctrl = '0;     // All control bits off by default

        // Operand fields come from whichever view holds them
        next_ctrl.rd  = instruction.reg_fmt.rd;
        next_ctrl.rs  = instruction.reg_fmt.rs;
        next_ctrl.rt  = instruction.reg_fmt.rt;
        next_ctrl.imm = instruction.imm_fmt.imm;
        next_ctrl.nzp = instruction.br_fmt.nzp;

        case (instruction.reg_fmt.opcode)
            OP_BRNZP: begin
                next_ctrl.pc_branch = 1'b1;
            end
            OP_CMP: begin
                next_ctrl.alu_cmp_sel  = 1'b1;
                next_ctrl.nzp_write_en = 1'b1;
            end
            OP_ADD: begin
                next_ctrl.reg_write_en  = 1'b1;
                next_ctrl.reg_input_sel = SRC_ALU;
                next_ctrl.alu_arith_sel = ALU_ADD;
            end
            OP_SUB: begin
                next_ctrl.reg_write_en  = 1'b1;
                next_ctrl.reg_input_sel = SRC_ALU;
                next_ctrl.alu_arith_sel = ALU_SUB;
            end
            OP_MUL: begin
                next_ctrl.reg_write_en  = 1'b1;
                next_ctrl.reg_input_sel = SRC_ALU;
                next_ctrl.alu_arith_sel = ALU_MUL;
            end
            OP_DIV: begin
                next_ctrl.reg_write_en  = 1'b1;
                next_ctrl.reg_input_sel = SRC_ALU;
                next_ctrl.alu_arith_sel = ALU_DIV;
            end
            OP_LDR: begin
                next_ctrl.reg_write_en  = 1'b1;
                next_ctrl.reg_input_sel = SRC_MEM;
                next_ctrl.mem_read_en   = 1'b1;
            end
            OP_STR: begin
                next_ctrl.mem_write_en = 1'b1;
            end
            OP_CONST: begin
                next_ctrl.reg_write_en  = 1'b1;
                next_ctrl.reg_input_sel = SRC_IMM;
            end
            OP_RET: begin
                next_ctrl.ret = 1'b1;
            end
            default: begin
                // NOP and unassigned opcodes
            end
        endcase
    end

    // Latch once per instruction, hold through the remaining states
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
        end else if (core_state == ST_DECODE) begin
            ctrl <= next_ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== core_scheduler.sv ====
// Core state sequencer
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module core_scheduler (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    output gpu_core_pkg::core_state_t core_state,
    output logic                      prog_req_valid,
    input  logic                      prog_req_ready,
    output logic [`GPU_ADDR_W-1:0]    prog_req_addr,
    input  logic                      prog_rsp_valid,
    input  logic [`GPU_INSTR_W-1:0]   prog_rsp_data,
    input  logic [`GPU_ADDR_W-1:0]    pc,
    input  logic                      lsu_done,
    input  logic                      ret,
    output gpu_core_pkg::instr_t      instruction,
    output logic                      done
);
    import gpu_core_pkg::*;

    logic fetch_rsp;

    assign prog_req_addr = pc;    // PC only moves at the end of UPDATE

    // Response accepted once the request has gone out
    assign fetch_rsp = (core_state == ST_FETCH) && !prog_req_valid && prog_rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            core_state     <= ST_IDLE;
            prog_req_valid <= 1'b0;
            done           <= 1'b0;
        end else begin
            case (core_state)
                ST_IDLE: begin
                    if (start) begin
                        core_state     <= ST_FETCH;
                        prog_req_valid <= 1'b1;
                    end
                end
                ST_FETCH: begin
                    if (prog_req_valid && prog_req_ready) begin
                        prog_req_valid <= 1'b0;
                    end else if (fetch_rsp) begin
                        core_state <= ST_DECODE;
                    end
                end
                ST_DECODE:  core_state <= ST_REQUEST;
                ST_REQUEST: core_state <= ST_WAIT;
                ST_WAIT: begin
                    if (lsu_done) core_state <= ST_EXECUTE;    // Stalls on memory
                end
                ST_EXECUTE: core_state <= ST_UPDATE;
                ST_UPDATE: begin
                    if (ret) begin
                        core_state <= ST_DONE;
                        done       <= 1'b1;
                    end else begin
                        core_state     <= ST_FETCH;
                        prog_req_valid <= 1'b1;
                    end
                end
                default: begin
                    // DONE holds until reset
                end
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (fetch_rsp) instruction <= prog_rsp_data;
    end

endmodule

`default_nettype wire

// ==== program_counter.sv ====
// Program counter and NZP flags
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module program_counter (
    input  logic                        clk,
    input  logic                        reset,
    input  gpu_core_pkg::core_state_t   core_state,
    input  gpu_core_pkg::decoded_ctrl_t ctrl,
    input  logic [`GPU_WORD_W-1:0]      alu_out,
    output logic [`GPU_ADDR_W-1:0]      pc
);
    import gpu_core_pkg::*;

    logic [`GPU_NZP_W-1:0] nzp;
    logic                  branch_taken;

    // Flags as left by the last CMP
    assign branch_taken = ctrl.pc_branch && |(nzp & ctrl.nzp);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= '0;
            nzp <= '0;
        end else if (core_state == ST_IDLE) begin
            pc  <= '0;     // Start always runs from address 0
            nzp <= '0;
        end else if (core_state == ST_UPDATE) begin
            pc <= branch_taken ? ctrl.imm : pc + 1'b1;
            if (ctrl.nzp_write_en) nzp <= alu_out[`GPU_NZP_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
// Core register file
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  gpu_core_pkg::core_state_t   core_state,
    input  gpu_core_pkg::decoded_ctrl_t ctrl,
    input  logic [`GPU_WORD_W-1:0]      alu_out,
    input  logic [`GPU_WORD_W-1:0]      lsu_data,
    output logic [`GPU_WORD_W-1:0]      rs_value,
    output logic [`GPU_WORD_W-1:0]      rt_value
);
    import gpu_core_pkg::*;

    logic [`GPU_WORD_W-1:0] regs [`GPU_NUM_REGS];
    logic [`GPU_WORD_W-1:0] wr_data;

    assign rs_value = regs[ctrl.rs];
    assign rt_value = regs[ctrl.rt];

    always_comb begin
        case (ctrl.reg_input_sel)
            SRC_MEM: wr_data = lsu_data;
            SRC_IMM: wr_data = ctrl.imm;
            default: wr_data = alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `GPU_NUM_REGS; i++) regs[i] <= '0;
        end else if (core_state == ST_UPDATE && ctrl.reg_write_en) begin
            regs[ctrl.rd] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
// Arithmetic and compare unit
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module alu (
    input  logic                        clk,
    input  logic                        reset,
    input  gpu_core_pkg::core_state_t   core_state,
    input  gpu_core_pkg::decoded_ctrl_t ctrl,
    input  logic [`GPU_WORD_W-1:0]      rs_value,
    input  logic [`GPU_WORD_W-1:0]      rt_value,
    output logic [`GPU_WORD_W-1:0]      alu_out
);
    import gpu_core_pkg::*;

    logic [`GPU_NZP_W-1:0] cmp_flags;

    // Unsigned compare, laid out as NZP bits
    assign cmp_flags = {rs_value > rt_value, rs_value == rt_value, rs_value < rt_value};

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_out <= '0;
        end else if (core_state == ST_EXECUTE) begin
            if (ctrl.alu_cmp_sel) begin
                alu_out <= {{(`GPU_WORD_W - `GPU_NZP_W){1'b0}}, cmp_flags};
            end else begin
                case (ctrl.alu_arith_sel)
                    ALU_ADD: alu_out <= rs_value + rt_value;
                    ALU_SUB: alu_out <= rs_value - rt_value;
                    ALU_MUL: alu_out <= rs_value * rt_value;    // Low byte kept
                    default: alu_out <= (rt_value == '0) ? '0 : rs_value / rt_value;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== lsu.sv ====
// Load/store unit
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module lsu (
    input  logic                        clk,
    input  logic                        reset,
    input  gpu_core_pkg::core_state_t   core_state,
    input  gpu_core_pkg::decoded_ctrl_t ctrl,
    input  logic [`GPU_WORD_W-1:0]      rs_value,
    input  logic [`GPU_WORD_W-1:0]      rt_value,
    output logic                        mem_req_valid,
    input  logic                        mem_req_ready,
    output gpu_core_pkg::mem_req_t      mem_req,
    input  logic                        mem_rsp_valid,
    input  logic [`GPU_WORD_W-1:0]      mem_rsp_data,
    output logic [`GPU_WORD_W-1:0]      lsu_data,
    output logic                        lsu_done
);
    import gpu_core_pkg::*;

    logic mem_op;
    logic req_fire;

    assign mem_op   = ctrl.mem_read_en || ctrl.mem_write_en;
    assign req_fire = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req_valid <= 1'b0;
        end else if (core_state == ST_REQUEST && mem_op) begin
            mem_req_valid <= 1'b1;
        end else if (req_fire) begin
            mem_req_valid <= 1'b0;
        end
    end

    // Payload frozen from REQUEST until the handshake
    always_ff @(posedge clk) begin
        if (core_state == ST_REQUEST) begin
            mem_req.write <= ctrl.mem_write_en;
            mem_req.addr  <= rs_value;
            mem_req.wdata <= rt_value;
        end
        if (core_state == ST_WAIT && ctrl.mem_read_en && mem_rsp_valid) begin
            lsu_data <= mem_rsp_data;
        end
    end

    always_comb begin
        lsu_done = 1'b0;
        if (core_state == ST_WAIT) begin
            if (!mem_op) lsu_done = 1'b1;    // Nothing to wait for
            else if (ctrl.mem_write_en) lsu_done = req_fire;
            else lsu_done = mem_rsp_valid;
        end
    end

endmodule

`default_nettype wire

// ==== gpu_core.sv ====
// Single-thread GPU compute core
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module gpu_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    output logic                    done,
    // Program memory
    output logic                    prog_req_valid,
    input  logic                    prog_req_ready,
    output logic [`GPU_ADDR_W-1:0]  prog_req_addr,
    input  logic                    prog_rsp_valid,
    input  logic [`GPU_INSTR_W-1:0] prog_rsp_data,
    // Data memory
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output gpu_core_pkg::mem_req_t  mem_req,
    input  logic                    mem_rsp_valid,
    input  logic [`GPU_WORD_W-1:0]  mem_rsp_data
);
    import gpu_core_pkg::*;

    core_state_t            core_state;
    instr_t                 instruction;
    decoded_ctrl_t          ctrl;
    logic [`GPU_ADDR_W-1:0] pc;
    logic [`GPU_WORD_W-1:0] rs_value;
    logic [`GPU_WORD_W-1:0] rt_value;
    logic [`GPU_WORD_W-1:0] alu_out;
    logic [`GPU_WORD_W-1:0] lsu_data;
    logic                   lsu_done;

    core_scheduler scheduler_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .core_state     (core_state),
        .prog_req_valid (prog_req_valid),
        .prog_req_ready (prog_req_ready),
        .prog_req_addr  (prog_req_addr),
        .prog_rsp_valid (prog_rsp_valid),
        .prog_rsp_data  (prog_rsp_data),
        .pc             (pc),
        .lsu_done       (lsu_done),
        .ret            (ctrl.ret),
        .instruction    (instruction),
        .done           (done)
    );

    decoder decoder_inst (
        .clk         (clk),
        .reset       (reset),
        .core_state  (core_state),
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    program_counter pc_inst (
        .clk        (clk),
        .reset      (reset),
        .core_state (core_state),
        .ctrl       (ctrl),
        .alu_out    (alu_out),
        .pc         (pc)
    );

    register_file regfile_inst (
        .clk        (clk),
        .reset      (reset),
        .core_state (core_state),
        .ctrl       (ctrl),
        .alu_out    (alu_out),
        .lsu_data   (lsu_data),
        .rs_value   (rs_value),
        .rt_value   (rt_value)
    );

    alu alu_inst (
        .clk        (clk),
        .reset      (reset),
        .core_state (core_state),
        .ctrl       (ctrl),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .alu_out    (alu_out)
    );

    lsu lsu_inst (
        .clk           (clk),
        .reset         (reset),
        .core_state    (core_state),
        .ctrl          (ctrl),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .lsu_data      (lsu_data),
        .lsu_done      (lsu_done)
    );

endmodule

`default_nettype wire

// ==== gpu_core_assert.sv ====
// GPU core protocol assertions
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module gpu_core_assert (
    input logic                      clk,
    input logic                      reset,
    input gpu_core_pkg::core_state_t core_state,
    input logic                      prog_req_valid,
    input logic                      prog_req_ready,
    input logic [`GPU_ADDR_W-1:0]    prog_req_addr,
    input logic                      prog_rsp_valid,
    input logic                      mem_req_valid,
    input logic                      mem_req_ready,
    input gpu_core_pkg::mem_req_t    mem_req,
    input logic                      done
);
    import gpu_core_pkg::*;

    logic fetch_pending;    // Fetch accepted, response not yet back

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pending <= 1'b0;
        end else if (prog_req_valid && prog_req_ready) begin
            fetch_pending <= 1'b1;
        end else if (prog_rsp_valid) begin
            fetch_pending <= 1'b0;
        end
    end

    prog_hold: assert property (@(posedge clk) disable iff (reset)
        prog_req_valid && !prog_req_ready |=> prog_req_valid && $stable(prog_req_addr))
        else $error("prog request dropped or changed before ready");

    mem_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("data request dropped or changed before ready");

    no_refetch: assert property (@(posedge clk) disable iff (reset)
        fetch_pending |-> !prog_req_valid)
        else $error("fetch issued while a response is pending");

    done_sticky: assert property (@(posedge clk) disable iff (reset)
        done |=> done)
        else $error("done fell without reset");

    // LSU request must line up with the scheduler's WAIT state
    mem_req_in_wait: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> core_state == ST_WAIT)
        else $error("data request raised outside WAIT");

endmodule

`default_nettype wire

// ==== tb_gpu_core.sv ====
// GPU core testbench
`default_nettype none
`timescale 1ns/1ps

`include "gpu_core_defs.svh"

module tb_gpu_core;
    import gpu_core_pkg::*;

    localparam int DONE_TIMEOUT = 5000;
    localparam int IDLE_CYCLES  = 20;

    logic                    clk = 1'b0;
    logic                    reset = 1'b1;
    logic                    start = 1'b0;
    logic                    done;
    logic                    prog_req_valid;
    logic                    prog_req_ready = 1'b0;
    logic [`GPU_ADDR_W-1:0]  prog_req_addr;
    logic                    prog_rsp_valid = 1'b0;
    logic [`GPU_INSTR_W-1:0] prog_rsp_data = '0;
    logic                    mem_req_valid;
    logic                    mem_req_ready = 1'b0;
    mem_req_t                mem_req;
    logic                    mem_rsp_valid = 1'b0;
    logic [`GPU_WORD_W-1:0]  mem_rsp_data = '0;

    logic [`GPU_INSTR_W-1:0] prog_mem [256];
    logic [`GPU_WORD_W-1:0]  data_mem [256];

    integer seed = 18023;
    bit     stall_en = 1'b0;
    int     errors = 0;
    int     checks = 0;
    int     prog_len = 0;    // Next free program slot

    // Memory model state, sampled mid-cycle
    bit                     in_reset;
    bit                     stall_q;
    bit                     prog_fire;
    bit                     mem_fire;
    logic [`GPU_ADDR_W-1:0] prog_addr_q;
    mem_req_t               mem_req_q;
    int                     prog_wait = 0;
    int                     mem_wait = 0;

    gpu_core gpu_core_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .done           (done),
        .prog_req_valid (prog_req_valid),
        .prog_req_ready (prog_req_ready),
        .prog_req_addr  (prog_req_addr),
        .prog_rsp_valid (prog_rsp_valid),
        .prog_rsp_data  (prog_rsp_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data)
    );

    bind gpu_core gpu_core_assert gpu_core_assert_inst (
        .clk            (clk),
        .reset          (reset),
        .core_state     (core_state),
        .prog_req_valid (prog_req_valid),
        .prog_req_ready (prog_req_ready),
        .prog_req_addr  (prog_req_addr),
        .prog_rsp_valid (prog_rsp_valid),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .done           (done)
    );

    always #5 clk = ~clk;

    function automatic int response_delay();
        return 1 + ({$random(seed)} % 3);    // 1 to 3 cycles
    endfunction

    function automatic bit ready_level(input bit stalls);
        if (!stalls) return 1'b1;
        return ({$random(seed)} % 4) != 0;
    endfunction

    // Program and data memory in one process, so random draws keep a fixed order
    always begin
        @(negedge clk);
        in_reset  = reset;
        stall_q   = stall_en;
        prog_fire = prog_req_valid && prog_req_ready;
        mem_fire  = mem_req_valid && mem_req_ready;
        if (prog_fire) prog_addr_q = prog_req_addr;
        if (mem_fire) mem_req_q = mem_req;
        @(posedge clk);
        #1;
        prog_rsp_valid = 1'b0;
        mem_rsp_valid  = 1'b0;
        if (in_reset) begin
            prog_wait = 0;
            mem_wait  = 0;
        end else begin
            if (prog_fire) prog_wait = response_delay();
            if (mem_fire && mem_req_q.write) begin
                data_mem[mem_req_q.addr] = mem_req_q.wdata;    // No response for writes
            end else if (mem_fire) begin
                mem_wait = response_delay();
            end
            if (prog_wait > 0) begin
                prog_wait--;
                if (prog_wait == 0) begin
                    prog_rsp_valid = 1'b1;
                    prog_rsp_data  = prog_mem[prog_addr_q];
                end
            end
            if (mem_wait > 0) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = data_mem[mem_req_q.addr];
                end
            end
        end
        prog_req_ready = ready_level(stall_q);
        mem_req_ready  = ready_level(stall_q);
    end

    function automatic logic [15:0] reg_instr(input opcode_t op, input logic [3:0] rd,
                                              input logic [3:0] rs, input logic [3:0] rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic logic [15:0] imm_instr(input opcode_t op, input logic [3:0] rd,
                                              input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic logic [15:0] branch_instr(input logic [2:0] mask,
                                                 input logic [7:0] target);
        return {OP_BRNZP, mask, 1'b0, target};
    endfunction

    task automatic emit(input logic [15:0] word);
        prog_mem[8'(prog_len)] = word;
        prog_len++;
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            prog_mem[8'(i)] = {OP_RET, 4'h0, 8'(i)};    // RET past the end of any program
            data_mem[8'(i)] = 8'(i) ^ 8'h5A;
        end
        prog_len = 0;
    endtask

    task automatic expect_bit(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic expect_byte(input string name, input logic [7:0] addr,
                               input logic [7:0] expected);
        checks++;
        if (data_mem[addr] !== expected) begin
            errors++;
            $display("MISMATCH %s data_mem[%02h]: got %02h, expected %02h",
                     name, addr, data_mem[addr], expected);
        end
    endtask

    task automatic start_core(input bit stalls);
        stall_en = stalls;
        reset    = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        expect_bit("done", done, 1'b0);
        expect_bit("prog_req_valid", prog_req_valid, 1'b0);
        expect_bit("mem_req_valid", mem_req_valid, 1'b0);
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("%s: done did not rise within %0d cycles", name, DONE_TIMEOUT);
        end
    endtask

    task automatic arithmetic_results();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        a = 8'd200;
        b = 8'd100;
        c = 8'd7;
        clear_memories();
        emit(imm_instr(OP_CONST, 4'd1, a));
        emit(imm_instr(OP_CONST, 4'd2, b));
        emit(imm_instr(OP_CONST, 4'd3, c));
        emit(imm_instr(OP_CONST, 4'd4, 8'd0));
        emit(reg_instr(OP_ADD, 4'd5, 4'd1, 4'd2));
        emit(reg_instr(OP_SUB, 4'd6, 4'd2, 4'd1));
        emit(reg_instr(OP_MUL, 4'd7, 4'd1, 4'd3));
        emit(reg_instr(OP_DIV, 4'd8, 4'd1, 4'd3));
        emit(reg_instr(OP_DIV, 4'd9, 4'd1, 4'd4));     // Divide by zero
        emit(imm_instr(OP_CONST, 4'd10, 8'h20));       // Result base address
        emit(imm_instr(OP_CONST, 4'd11, 8'd1));
        for (int r = 5; r <= 9; r++) begin
            emit(reg_instr(OP_STR, 4'd0, 4'd10, 4'(r)));
            emit(reg_instr(OP_ADD, 4'd10, 4'd10, 4'd11));
        end
        emit(imm_instr(OP_RET, 4'd0, 8'd0));
        start_core(1'b0);
        wait_done("arithmetic");
        expect_byte("add", 8'h20, a + b);    // Wraps past 255
        expect_byte("sub", 8'h21, b - a);
        expect_byte("mul", 8'h22, a * c);
        expect_byte("div", 8'h23, a / c);
        expect_byte("div by zero", 8'h24, 8'h00);
    endtask

    task automatic load_store_copy();
        logic [7:0] src [4];
        logic [7:0] scale;
        src[0] = 8'h11;
        src[1] = 8'h80;
        src[2] = 8'hF3;
        src[3] = 8'h07;
        scale  = 8'd3;
        clear_memories();
        for (int i = 0; i < 4; i++) data_mem[8'(8'h40 + i)] = src[2'(i)];
        emit(imm_instr(OP_CONST, 4'd1, 8'h40));    // Source pointer
        emit(imm_instr(OP_CONST, 4'd2, 8'd1));
        emit(imm_instr(OP_CONST, 4'd3, 8'h50));    // Destination pointer
        emit(imm_instr(OP_CONST, 4'd4, scale));
        for (int i = 0; i < 4; i++) begin
            emit(reg_instr(OP_LDR, 4'd5, 4'd1, 4'd0));
            emit(reg_instr(OP_MUL, 4'd6, 4'd5, 4'd4));
            emit(reg_instr(OP_STR, 4'd0, 4'd3, 4'd6));
            emit(reg_instr(OP_ADD, 4'd1, 4'd1, 4'd2));
            emit(reg_instr(OP_ADD, 4'd3, 4'd3, 4'd2));
        end
        emit(imm_instr(OP_RET, 4'd0, 8'd0));
        start_core(1'b0);
        wait_done("load/store");
        for (int i = 0; i < 4; i++) begin
            expect_byte("scaled copy", 8'(8'h50 + i), src[2'(i)] * scale);
        end
        expect_byte("untouched", 8'h54, 8'h54 ^ 8'h5A);
    endtask

    task automatic countdown_loop(input bit stalls, input string name);
        logic [7:0] count;
        logic [7:0] iters;
        int         loop_top;
        int         skip_to;
        clear_memories();
        emit(imm_instr(OP_CONST, 4'd1, 8'd9));     // Counter
        emit(imm_instr(OP_CONST, 4'd2, 8'd1));
        emit(imm_instr(OP_CONST, 4'd3, 8'd0));     // Iterations
        emit(imm_instr(OP_CONST, 4'd4, 8'd0));
        loop_top = prog_len;
        emit(reg_instr(OP_SUB, 4'd1, 4'd1, 4'd2));
        emit(reg_instr(OP_ADD, 4'd3, 4'd3, 4'd2));
        emit(reg_instr(OP_CMP, 4'd0, 4'd1, 4'd4));
        emit(branch_instr(3'b100, 8'(loop_top)));  // Loop while counter > 0
        emit(reg_instr(OP_CMP, 4'd0, 4'd1, 4'd4));
        skip_to = prog_len + 2;
        emit(branch_instr(3'b101, 8'(skip_to)));   // Flags are equal here, so falls through
        emit(imm_instr(OP_CONST, 4'd5, 8'h77));
        emit(imm_instr(OP_CONST, 4'd6, 8'h60));
        emit(reg_instr(OP_STR, 4'd0, 4'd6, 4'd1));
        emit(imm_instr(OP_CONST, 4'd6, 8'h61));
        emit(reg_instr(OP_STR, 4'd0, 4'd6, 4'd3));
        emit(imm_instr(OP_CONST, 4'd6, 8'h62));
        emit(reg_instr(OP_STR, 4'd0, 4'd6, 4'd5));
        emit(imm_instr(OP_RET, 4'd0, 8'd0));
        start_core(stalls);
        wait_done(name);
        count = 8'd9;
        iters = 8'd0;
        do begin
            count = count - 8'd1;
            iters = iters + 8'd1;
        end while (count > 8'd0);
        expect_byte("final counter", 8'h60, count);
        expect_byte("iterations", 8'h61, iters);
        expect_byte("not-taken branch", 8'h62, 8'h77);
    endtask

    task automatic return_idle();
        clear_memories();
        emit(imm_instr(OP_CONST, 4'd1, 8'h70));
        emit(imm_instr(OP_CONST, 4'd2, 8'h3C));
        emit(reg_instr(OP_STR, 4'd0, 4'd1, 4'd2));
        emit(imm_instr(OP_RET, 4'd0, 8'd0));
        start_core(1'b0);
        wait_done("return");
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(posedge clk);
            #1;
            expect_bit("prog_req_valid", prog_req_valid, 1'b0);
            expect_bit("mem_req_valid", mem_req_valid, 1'b0);
            expect_bit("done", done, 1'b1);
        end
        expect_byte("store before RET", 8'h70, 8'h3C);
    endtask

    initial begin
        arithmetic_results();
        load_store_copy();
        countdown_loop(1'b0, "countdown");
        countdown_loop(1'b1, "countdown with stalls");
        return_idle();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== gpu_core.f ====
+incdir+.
gpu_core_pkg.sv
decoder.sv
core_scheduler.sv
program_counter.sv
register_file.sv
alu.sv
lsu.sv
gpu_core.sv
gpu_core_assert.sv
tb_gpu_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_gpu_core
FILELIST  := gpu_core.f
PASS_MSG  := No errors

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) gpu_core_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
